//--- key_sorter.f
source/sort_config_pkg.sv
source/sort_data_pkg.sv
source/compare_exchange.sv
source/bitonic_stage.sv
source/bitonic_network.sv
source/key_loader.sv
source/result_unloader.sv
source/key_sorter.sv
tests/key_sorter_tb.sv

//--- source/bitonic_network.sv
`default_nettype none

module bitonic_network (
    input wire clk,
    input wire reset,
    input wire group_valid,
    input wire sort_data_pkg::sort_group_t group,
    output logic sorted_valid,
    output sort_data_pkg::sort_group_t sorted
);

    import sort_config_pkg::*;
    import sort_data_pkg::*;

    // Build 2-sequences, merge to 4, then merge to 8
    localparam int STAGE_BLOCK [NETWORK_STAGES] = '{2, 4, 4, 8, 8, 8};
    localparam int STAGE_DIST [NETWORK_STAGES] = '{1, 2, 1, 4, 2, 1};

    logic stage_valid [NETWORK_STAGES+1];
    sort_group_t stage_group [NETWORK_STAGES+1];

    assign stage_valid[0] = group_valid;
    assign stage_group[0] = group;

    genvar s;
    generate
        for (s = 0; s < NETWORK_STAGES; s = s + 1) begin : g_stage
            bitonic_stage #(
                .block_size(STAGE_BLOCK[s]),
                .distance(STAGE_DIST[s])
            ) u_stage (
                .clk(clk),
                .reset(reset),
                .valid(stage_valid[s]),     // Previous stage's done
                .group(stage_group[s]),
                .group_out(stage_group[s+1]),
                .done(stage_valid[s+1])
            );
        end
    endgenerate

    // Slot 0 holds the smallest key
    assign sorted_valid = stage_valid[NETWORK_STAGES];
    assign sorted = stage_group[NETWORK_STAGES];

endmodule

`default_nettype wire

//--- source/bitonic_stage.sv
`default_nettype none

module bitonic_stage #(
    parameter int block_size = 2,
    parameter int distance = 1
) (
    input wire clk,
    input wire reset,
    input wire valid,
    input wire sort_data_pkg::sort_group_t group,
    output sort_data_pkg::sort_group_t group_out,
    output logic done
);

    import sort_config_pkg::*;

    genvar p;
    generate
        for (p = 0; p < GROUP_SIZE / 2; p = p + 1) begin : g_pair
            // Lower slot of pair p, partner sits distance above
            localparam int LO = (p / distance) * 2 * distance + (p % distance);
            localparam int HI = LO + distance;
            // Even blocks ascend, odd blocks descend
            localparam bit UP = ((LO / block_size) % 2) == 0;

            if (p == 0) begin : g_first
                compare_exchange #(
                    .ascending(UP)
                ) u_cx (
                    .clk(clk),
                    .reset(reset),
                    .ready(valid),
                    .in_a(group.entry[LO]),
                    .in_b(group.entry[HI]),
                    .out_a(group_out.entry[LO]),
                    .out_b(group_out.entry[HI]),
                    .done(done)             // Same timing in every pair
                );
            end else begin : g_rest
                compare_exchange #(
                    .ascending(UP)
                ) u_cx (
                    .clk(clk),
                    .reset(reset),
                    .ready(valid),
                    .in_a(group.entry[LO]),
                    .in_b(group.entry[HI]),
                    .out_a(group_out.entry[LO]),
                    .out_b(group_out.entry[HI]),
                    .done()
                );
            end
        end
    endgenerate

endmodule

`default_nettype wire

//--- source/compare_exchange.sv
`default_nettype none

module compare_exchange #(
    parameter bit ascending = 1'b1
) (
    input wire clk,
    input wire reset,
    input wire ready,
    input wire sort_data_pkg::sort_entry_t in_a,
    input wire sort_data_pkg::sort_entry_t in_b,
    output sort_data_pkg::sort_entry_t out_a,
    output sort_data_pkg::sort_entry_t out_b,
    output logic done
);

    logic swap;

    // Ties leave unswapped
    always_comb begin
        if (ascending) begin
            swap = in_a.key > in_b.key;     // Smaller key goes to out_a
        end else begin
            swap = in_a.key < in_b.key;     // Larger key goes to out_a
        end
    end

    always_ff @(posedge clk) begin
        if (ready) begin
            if (swap) begin
                out_a <= in_b;
                out_b <= in_a;
            end else begin
                out_a <= in_a;
                out_b <= in_b;
            end
        end
    end

    // One pulse per accepted pair
    always_ff @(posedge clk) begin
        if (reset) begin
            done <= 1'b0;
        end else begin
            done <= ready;
        end
    end

endmodule

`default_nettype wire

//--- source/key_loader.sv
`default_nettype none

module key_loader (
    input wire clk,
    input wire reset,
    input wire key_valid,
    input wire [sort_config_pkg::KEY_WIDTH-1:0] key,
    output logic group_valid,
    output sort_data_pkg::sort_group_t group
);

    import sort_config_pkg::*;
    import sort_data_pkg::*;

    logic [LOAD_COUNT_WIDTH-1:0] slot;
    logic slot_last;
    sort_group_t collect;
    sort_group_t filled;

    assign slot_last = slot == LOAD_COUNT_WIDTH'(GROUP_SIZE - 1);

    // Collecting register with the incoming key dropped in
    always_comb begin
        filled = collect;
        filled.entry[slot].key = key;
        filled.entry[slot].index = INDEX_WIDTH'(slot);  // Arrival order tag
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            slot <= '0;
            group_valid <= 1'b0;
        end else begin
            group_valid <= key_valid && slot_last;
            if (key_valid) begin
                slot <= slot_last ? '0 : slot + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (key_valid) begin
            collect <= filled;
            if (slot_last) begin
                group <= filled;            // Free to refill next cycle
            end
        end
    end

endmodule

`default_nettype wire

//--- source/key_sorter.sv
`default_nettype none

module key_sorter (
    input wire clk,
    input wire reset,
    input wire key_valid,
    input wire [sort_config_pkg::KEY_WIDTH-1:0] key,
    output logic out_valid,
    output sort_data_pkg::sorted_out_t out
);

    import sort_data_pkg::*;

    logic group_valid;
    sort_group_t group;
    logic sorted_valid;
    sort_group_t sorted;

    key_loader u_loader (
        .clk(clk),
        .reset(reset),
        .key_valid(key_valid),
        .key(key),
        .group_valid(group_valid),
        .group(group)
    );

    // Six cycles deep, several groups in flight
    bitonic_network u_network (
        .clk(clk),
        .reset(reset),
        .group_valid(group_valid),
        .group(group),
        .sorted_valid(sorted_valid),
        .sorted(sorted)
    );

    result_unloader u_unloader (
        .clk(clk),
        .reset(reset),
        .sorted_valid(sorted_valid),
        .sorted(sorted),
        .out_valid(out_valid),
        .out(out)
    );

endmodule

`default_nettype wire

//--- source/result_unloader.sv
`default_nettype none

module result_unloader (
    input wire clk,
    input wire reset,
    input wire sorted_valid,
    input wire sort_data_pkg::sort_group_t sorted,
    output logic out_valid,
    output sort_data_pkg::sorted_out_t out
);

    import sort_config_pkg::*;
    import sort_data_pkg::*;

    sort_group_t shift;
    logic [$clog2(GROUP_SIZE)-1:0] remaining;   // Entries still to send

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            out.last <= 1'b0;
            remaining <= '0;
        end else if (sorted_valid) begin
            out_valid <= 1'b1;
            out.last <= 1'b0;
            remaining <= $bits(remaining)'(GROUP_SIZE - 1);
        end else if (remaining != '0) begin
            out_valid <= 1'b1;
            out.last <= remaining == 1'b1;
            remaining <= remaining - 1'b1;
        end else begin
            out_valid <= 1'b0;
            out.last <= 1'b0;
        end
    end

    // Entry 0 goes straight out, the rest step down one slot per cycle
    always_ff @(posedge clk) begin
        if (sorted_valid) begin
            shift <= sorted;
            out.entry <= sorted.entry[0];
        end else if (remaining != '0) begin
            shift.entry[GROUP_SIZE-2:0] <= shift.entry[GROUP_SIZE-1:1];
            out.entry <= shift.entry[1];
        end
    end

endmodule

`default_nettype wire

//--- source/sort_config_pkg.sv
`default_nettype none

package sort_config_pkg;

    // Key and tag widths
    localparam int KEY_WIDTH = 16;
    localparam int INDEX_WIDTH = 3;

    // One group is sorted as a whole
    localparam int GROUP_SIZE = 8;

    // log2(8) * (log2(8) + 1) / 2 compare levels
    localparam int NETWORK_STAGES = 6;

    localparam int LOAD_COUNT_WIDTH = 3;    // Counts 0 to GROUP_SIZE-1

endpackage

`default_nettype wire

//--- source/sort_data_pkg.sv
`default_nettype none

package sort_data_pkg;

    import sort_config_pkg::*;

    // Key with the slot it arrived in
    typedef struct packed {
        logic [KEY_WIDTH-1:0] key;
        logic [INDEX_WIDTH-1:0] index;
    } sort_entry_t;

    // entry[0] is the lowest slot
    typedef struct packed {
        sort_entry_t [GROUP_SIZE-1:0] entry;
    } sort_group_t;

    // Streamed result word
    typedef struct packed {
        sort_entry_t entry;
        logic last;                         // Final entry of a group
    } sorted_out_t;

endpackage

`default_nettype wire

//--- tests/key_sorter_tb.sv
`default_nettype none

module key_sorter_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import sort_config_pkg::*;
    import sort_data_pkg::*;

    localparam int RANDOM_GROUPS = 20;
    localparam int BURST_GROUPS = 12;
    localparam int EDGE_GROUPS = 6;
    localparam int TOTAL_GROUPS = 1 + RANDOM_GROUPS + BURST_GROUPS + EDGE_GROUPS;
    localparam int TIMEOUT_CYCLES = 12 * TOTAL_GROUPS + 100;
    localparam int LATENCY = 8;             // Eighth key edge to first output
    localparam int MAX_GAPS = 3;            // Idle cycles allowed per random group

    logic clk;
    logic reset;
    logic key_valid;
    logic [KEY_WIDTH-1:0] key;
    logic out_valid;
    sorted_out_t out;

    int cycle = 0;
    logic [15:0] lfsr_state;
    string test_name;

    // Scoreboard filled from the sampled inputs
    logic [GROUP_SIZE-1:0][KEY_WIDTH-1:0] load_keys;
    string load_test;
    logic [GROUP_SIZE-1:0][KEY_WIDTH-1:0] fed_key [TOTAL_GROUPS+1];
    int fed_edge [TOTAL_GROUPS+1];
    string group_test [TOTAL_GROUPS+1];
    int load_slot = 0;
    int groups_fed = 0;
    int groups_out = 0;
    int out_pos = 0;
    logic [GROUP_SIZE-1:0][KEY_WIDTH-1:0] expected_keys;
    logic [GROUP_SIZE-1:0] index_seen;

    key_sorter key_sorter_i (
        .clk(clk),
        .reset(reset),
        .key_valid(key_valid),
        .key(key),
        .out_valid(out_valid),
        .out(out)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // 16-bit Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    task automatic take_random_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int b = 0; b < count; b++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // Reference bubble sort with the smallest key in slot 0
    function automatic logic [GROUP_SIZE-1:0][KEY_WIDTH-1:0] sort_keys(
        input logic [GROUP_SIZE-1:0][KEY_WIDTH-1:0] keys
    );
        logic [GROUP_SIZE-1:0][KEY_WIDTH-1:0] s;
        logic [KEY_WIDTH-1:0] t;
        s = keys;
        for (int i = 0; i < GROUP_SIZE - 1; i++) begin
            for (int j = 0; j < GROUP_SIZE - 1 - i; j++) begin
                if (s[j] > s[j+1]) begin
                    t = s[j];
                    s[j] = s[j+1];
                    s[j+1] = t;
                end
            end
        end
        return s;
    endfunction

    function automatic logic [KEY_WIDTH-1:0] edge_key(input int kind, input int i);
        case (kind)
            0: return 16'h5A5A;
            1: return '0;
            2: return '1;
            3: return i[0] ? '1 : '0;
            4: return KEY_WIDTH'(i * 16'h1111);
            default: return KEY_WIDTH'((GROUP_SIZE - 1 - i) * 16'h1111);
        endcase
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "%s", msg);
    endtask

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s %s: expected %0h, actual %0h", test, what, expected, actual);
            report_failure("Output differs from the reference");
        end
    endtask

    task automatic drive_key(input logic [KEY_WIDTH-1:0] value);
        @(posedge clk);
        key_valid <= 1'b1;
        key <= value;
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) begin
            @(posedge clk);
            key_valid <= 1'b0;
        end
    endtask

    // Groups as the DUT samples them
    always @(negedge clk) begin : record_input
        if (!reset && key_valid === 1'b1) begin
            if (load_slot == 0) begin
                load_test = test_name;      // Group belongs to the test of its first key
            end
            load_keys[load_slot] = key;
            if (load_slot == GROUP_SIZE - 1) begin
                fed_key[groups_fed] = load_keys;
                fed_edge[groups_fed] = cycle + 1;   // Edge that takes the eighth key
                group_test[groups_fed] = load_test;
                groups_fed = groups_fed + 1;
                load_slot = 0;
            end else begin
                load_slot = load_slot + 1;
            end
        end
    end

    always @(negedge clk) begin : compare_output
        logic [INDEX_WIDTH-1:0] idx;
        if (!reset && out_valid !== 1'b0) begin
            if (out_valid !== 1'b1) begin
                report_failure("out_valid is unknown after reset");
            end
            if (groups_out >= groups_fed) begin
                report_failure("out_valid rose with no complete group pending");
            end
            if (out_pos == 0) begin
                expected_keys = sort_keys(fed_key[groups_out]);
                index_seen = '0;
            end
            idx = out.entry.index;
            // Next edge is the one that samples this entry
            check_value(group_test[groups_out], "cycle",
                        fed_edge[groups_out] + LATENCY + out_pos, cycle + 1);
            check_value(group_test[groups_out], "key", expected_keys[out_pos], out.entry.key);
            check_value(group_test[groups_out], "last", out_pos == GROUP_SIZE - 1, out.last);
            check_value(group_test[groups_out], "key at index",
                        fed_key[groups_out][idx], out.entry.key);
            check_value(group_test[groups_out], "index repeated", 0, index_seen[idx]);
            index_seen[idx] = 1'b1;
            if (out_pos == GROUP_SIZE - 1) begin
                groups_out = groups_out + 1;
                out_pos = 0;
            end else begin
                out_pos = out_pos + 1;
            end
        end
    end

    always @(negedge clk) begin : watchdog
        if (cycle > TIMEOUT_CYCLES) begin
            report_failure($sformatf("Timeout after %0d cycles with %0d of %0d groups sorted",
                                     cycle, groups_out, groups_fed));
        end
    end

    initial begin
        logic [31:0] r;
        int gaps;
        lfsr_state = 16'd98;
        reset = 1'b1;
        key_valid = 1'b0;
        key = '0;
        test_name = "reset";
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        // Seven keys must not release a group
        test_name = "partial_group";
        for (int i = 0; i < GROUP_SIZE - 1; i++) begin
            take_random_bits(KEY_WIDTH, r);
            drive_key(r[KEY_WIDTH-1:0]);
        end
        idle_cycles(20);
        take_random_bits(KEY_WIDTH, r);
        drive_key(r[KEY_WIDTH-1:0]);
        idle_cycles(1);

        test_name = "random_gaps";
        for (int g = 0; g < RANDOM_GROUPS; g++) begin
            gaps = 0;
            for (int i = 0; i < GROUP_SIZE; i++) begin
                take_random_bits(2, r);
                if (r[1:0] == 2'b11 && gaps < MAX_GAPS) begin
                    idle_cycles(1);
                    gaps = gaps + 1;
                end
                take_random_bits(KEY_WIDTH, r);
                drive_key(r[KEY_WIDTH-1:0]);
            end
        end
        idle_cycles(1);

        test_name = "back_to_back";
        for (int i = 0; i < BURST_GROUPS * GROUP_SIZE; i++) begin
            take_random_bits(KEY_WIDTH, r);
            drive_key(r[KEY_WIDTH-1:0]);
        end
        idle_cycles(1);

        for (int kind = 0; kind < EDGE_GROUPS; kind++) begin
            test_name = $sformatf("edge_values_%0d", kind);
            for (int i = 0; i < GROUP_SIZE; i++) begin
                drive_key(edge_key(kind, i));
            end
        end
        idle_cycles(1);

        wait (groups_out == groups_fed);
        idle_cycles(20);                    // No stray output after the last group
        if (groups_fed == TOTAL_GROUPS && groups_out == TOTAL_GROUPS && load_slot == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            report_failure($sformatf("Group count wrong: %0d fed, %0d sorted, %0d planned",
                                     groups_fed, groups_out, TOTAL_GROUPS));
        end
    end

endmodule

`default_nettype wire
